//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_soc_ctrl
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src.f
verilog/soc_ctrl_pkg.sv
verilog/cdc_sync.sv
verilog/apb_decoder.sv
verilog/apb_prci.sv
verilog/apb_gpio.sv
verilog/soc_ctrl_top.sv
verif/tb_clk_gen.sv
verif/soc_ctrl_checker.sv
verif/tb_scoreboard.sv
verif/tb_soc_ctrl.sv

//--- verif/soc_ctrl_checker.sv
`timescale 1ns/1ps

module soc_ctrl_checker
  import soc_ctrl_pkg::*;
(
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_psel,
  input logic              i_penable,
  input logic              i_pready,
  input logic              i_pslverr,
  input logic              i_pll_locked,
  input logic              i_sys_rst_n,
  input logic [GPIO_W-1:0] i_gpio_out,
  input logic [GPIO_W-1:0] i_gpio_oe
);

  int fail_cnt = 0;

  a_ready_in_access : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pready |-> (i_psel && i_penable))
    else begin
      $error("pready outside an access phase");
      fail_cnt++;
    end

  a_slverr_with_ready : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pslverr |-> i_pready)
    else begin
      $error("pslverr without pready");
      fail_cnt++;
    end

  // Lock low for three sampled cycles must have taken the system reset down
  a_lock_loss_reset : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!$past(i_pll_locked, 1) && !$past(i_pll_locked, 2) && !$past(i_pll_locked, 3))
      |-> !i_sys_rst_n)
    else begin
      $error("sys reset still released after lock loss");
      fail_cnt++;
    end

  a_gpio_masked : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_gpio_out & ~i_gpio_oe) == '0)
    else begin
      $error("gpio drives a pin that is not an output");
      fail_cnt++;
    end

endmodule

bind soc_ctrl_top soc_ctrl_checker u_checker (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_psel      (i_psel),
  .i_penable   (i_penable),
  .i_pready    (o_pready),
  .i_pslverr   (o_pslverr),
  .i_pll_locked(i_pll_locked),
  .i_sys_rst_n (o_sys_rst_n),
  .i_gpio_out  (o_gpio_out),
  .i_gpio_oe   (o_gpio_oe)
);

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 16
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Release away from the rising edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

//--- verif/tb_scoreboard.sv
`timescale 1ns/1ps

module tb_scoreboard
  import soc_ctrl_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_done,
  input  logic              i_chk,
  input  logic              i_pwrite,
  input  logic [APB_DW-1:0] i_prdata,
  input  logic [APB_DW-1:0] i_exp_rdata,
  input  logic              i_pready,
  input  logic              i_pslverr,
  input  logic              i_exp_slverr,
  input  logic [GPIO_W-1:0] i_gpio_out,
  input  logic [GPIO_W-1:0] i_exp_out,
  input  logic [GPIO_W-1:0] i_gpio_oe,
  input  logic [GPIO_W-1:0] i_exp_oe,
  input  int                i_tb_errs,
  input  int                i_sva_errs,
  output int                o_err_cnt
);

  initial o_err_cnt = 0;

  // Sample once per access phase
  always @(posedge i_clk) begin
    if (i_chk) begin
      if (i_pready !== 1'b1) begin
        $display("error: t=%0t o_pready expected 1 got %b", $time, i_pready);
        o_err_cnt++;
      end
      if (i_pslverr !== i_exp_slverr) begin
        $display("error: t=%0t o_pslverr expected %b got %b", $time, i_exp_slverr, i_pslverr);
        o_err_cnt++;
      end
      if (!i_pwrite && (i_prdata !== i_exp_rdata)) begin
        $display("error: t=%0t o_prdata expected %h got %h", $time, i_exp_rdata, i_prdata);
        o_err_cnt++;
      end
      if (i_gpio_oe !== i_exp_oe) begin
        $display("error: t=%0t o_gpio_oe expected %h got %h", $time, i_exp_oe, i_gpio_oe);
        o_err_cnt++;
      end
      if (i_gpio_out !== i_exp_out) begin
        $display("error: t=%0t o_gpio_out expected %h got %h", $time, i_exp_out, i_gpio_out);
        o_err_cnt++;
      end
    end
  end

  always @(posedge i_done) begin
    $display("errors: scoreboard=%0d testbench=%0d assertions=%0d",
             o_err_cnt, i_tb_errs, i_sva_errs);
  end

endmodule

//--- verif/tb_soc_ctrl.sv
`timescale 1ns/1ps

module tb_soc_ctrl
  import soc_ctrl_pkg::*;
();

  localparam int WAIT_MAX = 100;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              pll_locked;
  logic              calib_done;
  logic              sys_rst_n;
  logic              dbg_rst_n;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;

  // Reference model state
  logic [GPIO_W-1:0]    m_out;
  logic [GPIO_W-1:0]    m_dir;
  logic [RST_CNT_W-1:0] m_rst_cnt;
  logic                 m_released;

  // Expected values for the scoreboard
  logic              chk;
  logic [APB_DW-1:0] exp_rdata;
  logic              exp_slverr;
  logic [GPIO_W-1:0] exp_out;
  logic [GPIO_W-1:0] exp_oe;
  logic              done;
  int                tb_errs;
  int                sb_errs;
  int                sva_errs;

  tb_clk_gen u_clk_gen (
    .o_clk  (clk),
    .o_rst_n(rst_n)
  );

  soc_ctrl_top UUT (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_psel          (psel),
    .i_penable       (penable),
    .i_pwrite        (pwrite),
    .i_paddr         (paddr),
    .i_pwdata        (pwdata),
    .o_prdata        (prdata),
    .o_pready        (pready),
    .o_pslverr       (pslverr),
    .i_pll_locked    (pll_locked),
    .i_ddr_calib_done(calib_done),
    .o_sys_rst_n     (sys_rst_n),
    .o_dbg_rst_n     (dbg_rst_n),
    .i_gpio          (gpio_in),
    .o_gpio_out      (gpio_out),
    .o_gpio_oe       (gpio_oe)
  );

  assign sva_errs = UUT.u_checker.fail_cnt;

  tb_scoreboard u_scoreboard (
    .i_clk       (clk),
    .i_done      (done),
    .i_chk       (chk),
    .i_pwrite    (pwrite),
    .i_prdata    (prdata),
    .i_exp_rdata (exp_rdata),
    .i_pready    (pready),
    .i_pslverr   (pslverr),
    .i_exp_slverr(exp_slverr),
    .i_gpio_out  (gpio_out),
    .i_exp_out   (exp_out),
    .i_gpio_oe   (gpio_oe),
    .i_exp_oe    (exp_oe),
    .i_tb_errs   (tb_errs),
    .i_sva_errs  (sva_errs),
    .o_err_cnt   (sb_errs)
  );

  function automatic logic [APB_DW-1:0] model_read(input logic [APB_AW-1:0] addr);
    logic [REGION_W-1:0] region;
    logic [OFFS_W-1:0]   offs;
    logic [APB_DW-1:0]   data;
    region = addr[APB_AW-1:OFFS_W];
    offs   = addr[OFFS_W-1:0];
    data   = '0;
    if (region == REGION_PRCI) begin
      if (offs == PRCI_STATUS) begin
        data = {{(APB_DW-3){1'b0}}, calib_done, pll_locked, m_released};
      end else if (offs == PRCI_RST_CNT) begin
        data = {{(APB_DW-RST_CNT_W){1'b0}}, m_rst_cnt};
      end
    end else if (region == REGION_GPIO) begin
      if (offs == GPIO_OUT) begin
        data = {{(APB_DW-GPIO_W){1'b0}}, m_out};
      end else if (offs == GPIO_DIR) begin
        data = {{(APB_DW-GPIO_W){1'b0}}, m_dir};
      end else if (offs == GPIO_IN) begin
        data = {{(APB_DW-GPIO_W){1'b0}}, gpio_in};
      end
    end
    return data;
  endfunction

  // One setup and one access phase, model updated after the access edge
  task automatic apb_access(input logic [APB_AW-1:0] addr, input logic wr,
                            input logic [APB_DW-1:0] wdata);
    logic [REGION_W-1:0] region;
    logic [OFFS_W-1:0]   offs;
    region = addr[APB_AW-1:OFFS_W];
    offs   = addr[OFFS_W-1:0];
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable    = 1'b1;
    exp_rdata  = model_read(addr);
    exp_slverr = (region != REGION_PRCI) && (region != REGION_GPIO);
    exp_out    = m_out & m_dir;
    exp_oe     = m_dir;
    chk        = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    chk     = 1'b0;
    if (wr && region == REGION_GPIO) begin
      if (offs == GPIO_OUT) m_out = wdata[GPIO_W-1:0];
      if (offs == GPIO_DIR) m_dir = wdata[GPIO_W-1:0];
    end
    if (wr && region == REGION_PRCI && offs == PRCI_CTRL && wdata[0]) begin
      if (m_released) m_rst_cnt = m_rst_cnt + 8'd1;
      m_released = 1'b0;
    end
  endtask

  // Counts falling edges from now until the system reset lets go
  task automatic wait_release(input logic check_dbg);
    int n;
    int dbg_n;
    n     = 0;
    dbg_n = -1;
    while (!sys_rst_n && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
      if (dbg_rst_n && dbg_n < 0) dbg_n = n;
    end
    if (!sys_rst_n) begin
      $display("timeout: system reset never released after lock");
      tb_errs++;
    end else if (n < RST_HOLD_CYCLES || n > RST_HOLD_CYCLES + 3) begin
      $display("error: t=%0t o_sys_rst_n release cycles expected %0d..%0d got %0d",
               $time, RST_HOLD_CYCLES, RST_HOLD_CYCLES + 3, n);
      tb_errs++;
    end
    if (check_dbg && (dbg_n < 0 || dbg_n >= n)) begin
      $display("debug reset did not rise before the system reset");
      tb_errs++;
    end
    m_released = 1'b1;
  endtask

  task automatic lock_drop();
    int n;
    @(negedge clk);
    pll_locked = 1'b0;
    calib_done = 1'(($urandom) & 1);
    n = 0;
    while (sys_rst_n && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (sys_rst_n) begin
      $display("timeout: system reset stayed released after lock loss");
      tb_errs++;
    end else if (n > 3) begin
      $display("error: t=%0t o_sys_rst_n fall cycles expected <=3 got %0d", $time, n);
      tb_errs++;
    end
    if (dbg_rst_n) begin
      $display("error: t=%0t o_dbg_rst_n expected 0 got 1", $time);
      tb_errs++;
    end
    if (m_released) m_rst_cnt = m_rst_cnt + 8'd1;
    m_released = 1'b0;
    repeat ($urandom_range(1, 6)) @(negedge clk);
    pll_locked = 1'b1;
    wait_release(1'b1);
  endtask

  task automatic soft_reset();
    apb_access({REGION_PRCI, PRCI_CTRL}, 1'b1, $urandom | 32'h1);
    if (sys_rst_n) begin
      $display("error: t=%0t o_sys_rst_n expected 0 got 1", $time);
      tb_errs++;
    end
    wait_release(1'b0);
  endtask

  task automatic pins_change();
    @(negedge clk);
    gpio_in    = GPIO_W'($urandom);
    calib_done = 1'(($urandom) & 1);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    int                  n;
    int                  op;
    logic [REGION_W-1:0] region;
    logic [OFFS_W-1:0]   offs;
    logic [APB_DW-1:0]   wdata;
    logic                wr;
    void'($urandom(32'h6be66ea5));
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pll_locked = 1'b0;
    calib_done = 1'b0;
    gpio_in    = '0;
    chk        = 1'b0;
    exp_rdata  = '0;
    exp_slverr = 1'b0;
    exp_out    = '0;
    exp_oe     = '0;
    done       = 1'b0;
    tb_errs    = 0;
    m_out      = '0;
    m_dir      = '0;
    m_rst_cnt  = 8'd1;
    m_released = 1'b0;

    n = 0;
    while (rst_n !== 1'b1 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: i_rst_n never released");
      tb_errs++;
    end

    // Bring up the clock tree
    @(negedge clk);
    pll_locked = 1'b1;
    wait_release(1'b1);

    for (int i = 0; i < 300; i++) begin
      op = int'($urandom_range(0, 19));
      if (op == 0) begin
        lock_drop();
      end else if (op == 1) begin
        soft_reset();
      end else if (op <= 3) begin
        pins_change();
      end else if (op <= 5) begin
        region = 4'($urandom_range(2, 15));
        apb_access({region, 8'($urandom)}, 1'(($urandom) & 1), $urandom);
      end else begin
        region = 4'($urandom_range(0, 1));
        offs   = {4'h0, 2'($urandom), 2'b00};
        wr     = 1'(($urandom) & 1);
        wdata  = $urandom;
        // Soft requests only through soft_reset
        if (region == REGION_PRCI && offs == PRCI_CTRL) wdata[0] = 1'b0;
        apb_access({region, offs}, wr, wdata);
      end
    end

    repeat (4) @(negedge clk);
    done = 1'b1;
    #1;
    if (tb_errs + sb_errs + sva_errs != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

//--- verilog/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder
  import soc_ctrl_pkg::*;
(
  // Upstream APB slave port
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [APB_DW-1:0] i_pwdata,
  output logic [APB_DW-1:0] o_prdata,
  output logic              o_pready,
  output logic              o_pslverr,
  // Downstream to the slaves
  output logic              o_prci_sel,
  output logic              o_gpio_sel,
  output logic              o_penable,
  output logic              o_pwrite,
  output logic [OFFS_W-1:0] o_poffset,
  output logic [APB_DW-1:0] o_pwdata,
  input  logic [APB_DW-1:0] i_prci_rdata,
  input  logic [APB_DW-1:0] i_gpio_rdata
);

  logic [REGION_W-1:0] region;
  logic                hit_prci;
  logic                hit_gpio;
  logic                access;

  assign region   = i_paddr[APB_AW-1:OFFS_W];
  assign hit_prci = (region == REGION_PRCI);
  assign hit_gpio = (region == REGION_GPIO);
  assign access   = i_psel && i_penable;

  // Only a mapped region gets a select
  assign o_prci_sel = i_psel && hit_prci;
  assign o_gpio_sel = i_psel && hit_gpio;

  assign o_penable = i_penable;
  assign o_pwrite  = i_pwrite;
  assign o_poffset = i_paddr[OFFS_W-1:0];
  assign o_pwdata  = i_pwdata;

  // Zero wait states, every access phase completes
  assign o_pready  = access;
  assign o_pslverr = access && !hit_prci && !hit_gpio;

  always_comb begin
    if (hit_prci) begin
      o_prdata = i_prci_rdata;
    end else if (hit_gpio) begin
      o_prdata = i_gpio_rdata;
    end else begin
      o_prdata = '0;
    end
  end

endmodule

//--- verilog/apb_gpio.sv
`timescale 1ns/1ps

module apb_gpio
  import soc_ctrl_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  // APB slave side, offset only
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [OFFS_W-1:0] i_poffset,
  input  logic [APB_DW-1:0] i_pwdata,
  output logic [APB_DW-1:0] o_prdata,
  // Pin side
  input  logic [GPIO_W-1:0] i_gpio,
  output logic [GPIO_W-1:0] o_gpio_out,
  output logic [GPIO_W-1:0] o_gpio_oe
);

  logic              wr_en;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] pins_s;

  // Pin levels are asynchronous to i_clk
  cdc_sync #(
    .T(logic [GPIO_W-1:0])
  ) u_sync_pins (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_d    (i_gpio),
    .o_q    (pins_s)
  );

  assign wr_en = i_psel && i_penable && i_pwrite;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      case (i_poffset)
        GPIO_OUT: out_q <= i_pwdata[GPIO_W-1:0];
        GPIO_DIR: dir_q <= i_pwdata[GPIO_W-1:0];
        default:  ;
      endcase
    end
  end

  // Input pins drive 0
  assign o_gpio_out = out_q & dir_q;
  assign o_gpio_oe  = dir_q;

  always_comb begin
    case (i_poffset)
      GPIO_OUT: o_prdata = {{(APB_DW-GPIO_W){1'b0}}, out_q};
      GPIO_DIR: o_prdata = {{(APB_DW-GPIO_W){1'b0}}, dir_q};
      GPIO_IN:  o_prdata = {{(APB_DW-GPIO_W){1'b0}}, pins_s};
      default:  o_prdata = '0;
    endcase
  end

endmodule

//--- verilog/apb_prci.sv
`timescale 1ns/1ps

module apb_prci
  import soc_ctrl_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  // APB slave side, offset only
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [OFFS_W-1:0] i_poffset,
  input  logic [APB_DW-1:0] i_pwdata,
  output logic [APB_DW-1:0] o_prdata,
  // Levels from outside the clock domain
  input  logic              i_pll_locked,
  input  logic              i_ddr_calib_done,
  output logic              o_sys_rst_n,
  output logic              o_dbg_rst_n
);

  logic                  lock_s;
  logic                  calib_s;
  logic                  wr_en;
  logic                  soft_req;
  logic                  rst_drop;
  logic [HOLD_CNT_W-1:0] hold_cnt_q;
  logic                  sys_rst_n_q;
  logic                  dbg_rst_n_q;
  logic [RST_CNT_W-1:0]  rst_cnt_q;

  cdc_sync #(
    .T(logic)
  ) u_sync_lock (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_d    (i_pll_locked),
    .o_q    (lock_s)
  );

  cdc_sync #(
    .T(logic)
  ) u_sync_calib (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_d    (i_ddr_calib_done),
    .o_q    (calib_s)
  );

  assign wr_en    = i_psel && i_penable && i_pwrite;
  // Software reset, same role as the debug module reset
  assign soft_req = wr_en && (i_poffset == PRCI_CTRL) && i_pwdata[0];
  assign rst_drop = !lock_s || soft_req;

  // Debug domain only waits for lock
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dbg_rst_n_q <= 1'b0;
    end else begin
      dbg_rst_n_q <= lock_s;
    end
  end

  // Hold counter reloads on any drop and counts down while lock is stable
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hold_cnt_q  <= HOLD_CNT_W'(RST_HOLD_CYCLES - 1);
      sys_rst_n_q <= 1'b0;
      rst_cnt_q   <= RST_CNT_W'(1);  // power-on assertion counts as the first
    end else if (rst_drop) begin
      hold_cnt_q  <= HOLD_CNT_W'(RST_HOLD_CYCLES - 1);
      sys_rst_n_q <= 1'b0;
      if (sys_rst_n_q) begin
        rst_cnt_q <= rst_cnt_q + 1'b1;
      end
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end else begin
      sys_rst_n_q <= 1'b1;
    end
  end

  assign o_sys_rst_n = sys_rst_n_q;
  assign o_dbg_rst_n = dbg_rst_n_q;

  // CTRL reads back as zero
  always_comb begin
    case (i_poffset)
      PRCI_STATUS:  o_prdata = {{(APB_DW-3){1'b0}}, calib_s, lock_s, sys_rst_n_q};
      PRCI_RST_CNT: o_prdata = {{(APB_DW-RST_CNT_W){1'b0}}, rst_cnt_q};
      default:      o_prdata = '0;
    endcase
  end

endmodule

//--- verilog/cdc_sync.sv
`timescale 1ns/1ps

module cdc_sync
  import soc_ctrl_pkg::*;
#(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  T     i_d,
  output T     o_q
);

  // Flop chain, stage 0 may go metastable
  T sync_q [SYNC_STAGES];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= i_d;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign o_q = sync_q[SYNC_STAGES-1];

endmodule

//--- verilog/soc_ctrl_pkg.sv
package soc_ctrl_pkg;

  // APB bus widths
  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  // Address split: region in bits 11:8, register offset in bits 7:0
  localparam int REGION_W = 4;
  localparam int OFFS_W   = 8;

  localparam logic [REGION_W-1:0] REGION_PRCI = 4'h0;
  localparam logic [REGION_W-1:0] REGION_GPIO = 4'h1;

  // Pin count, same split as the board pads
  localparam int GPIO_W = 12;

  // Synchronizer depth for asynchronous levels
  localparam int SYNC_STAGES = 2;

  // Cycles of stable lock before the system reset lets go
  localparam int RST_HOLD_CYCLES = 16;
  localparam int HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES);

  // Width of the reset event counter
  localparam int RST_CNT_W = 8;

  // PRCI registers
  // STATUS bit 0 sys reset released, bit 1 PLL locked, bit 2 DDR calib done
  localparam logic [OFFS_W-1:0] PRCI_STATUS  = 8'h00;
  localparam logic [OFFS_W-1:0] PRCI_CTRL    = 8'h04;
  localparam logic [OFFS_W-1:0] PRCI_RST_CNT = 8'h08;

  // GPIO registers
  localparam logic [OFFS_W-1:0] GPIO_OUT = 8'h00;
  localparam logic [OFFS_W-1:0] GPIO_DIR = 8'h04;
  localparam logic [OFFS_W-1:0] GPIO_IN  = 8'h08;

endpackage

//--- verilog/soc_ctrl_top.sv
`timescale 1ns/1ps

module soc_ctrl_top
  import soc_ctrl_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  // APB slave port
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [APB_DW-1:0] i_pwdata,
  output logic [APB_DW-1:0] o_prdata,
  output logic              o_pready,
  output logic              o_pslverr,
  // Clock and reset control
  input  logic              i_pll_locked,
  input  logic              i_ddr_calib_done,
  output logic              o_sys_rst_n,
  output logic              o_dbg_rst_n,
  // GPIO pins
  input  logic [GPIO_W-1:0] i_gpio,
  output logic [GPIO_W-1:0] o_gpio_out,
  output logic [GPIO_W-1:0] o_gpio_oe
);

  logic              prci_sel;
  logic              gpio_sel;
  logic              penable;
  logic              pwrite;
  logic [OFFS_W-1:0] poffset;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prci_rdata;
  logic [APB_DW-1:0] gpio_rdata;

  apb_decoder u_decoder (
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_prci_sel  (prci_sel),
    .o_gpio_sel  (gpio_sel),
    .o_penable   (penable),
    .o_pwrite    (pwrite),
    .o_poffset   (poffset),
    .o_pwdata    (pwdata),
    .i_prci_rdata(prci_rdata),
    .i_gpio_rdata(gpio_rdata)
  );

  apb_prci u_prci (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_psel          (prci_sel),
    .i_penable       (penable),
    .i_pwrite        (pwrite),
    .i_poffset       (poffset),
    .i_pwdata        (pwdata),
    .o_prdata        (prci_rdata),
    .i_pll_locked    (i_pll_locked),
    .i_ddr_calib_done(i_ddr_calib_done),
    .o_sys_rst_n     (o_sys_rst_n),
    .o_dbg_rst_n     (o_dbg_rst_n)
  );

  apb_gpio u_gpio (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (gpio_sel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_poffset (poffset),
    .i_pwdata  (pwdata),
    .o_prdata  (gpio_rdata),
    .i_gpio    (i_gpio),
    .o_gpio_out(o_gpio_out),
    .o_gpio_oe (o_gpio_oe)
  );

endmodule
